/* fpm_settings.svh */
`ifndef FPM_SETTINGS_SVH
`define FPM_SETTINGS_SVH

// signed exponent width
`define FPM_EXP_W 8

// shift/step counter width
`define FPM_CNT_W 6

// exponent distance at which alignment shifts the whole mantissa out
`define FPM_FAR_LIMIT 40

// mantissa iterations for float multiply and divide
`define FPM_FLOAT_STEPS 40

// iterations for fixed multiply and divide
`define FPM_FIX_STEPS 16

`endif

/* fpm_ops_pkg.sv */
package fpm_ops_pkg;

	// arithmetic instruction code whose top bit selects float
	typedef enum logic [2:0] {
		op_ad = 3'd0,
		op_sd = 3'd1,
		op_mw = 3'd2,
		op_dw = 3'd3,
		op_af = 3'd4,
		op_sf = 3'd5,
		op_mf = 3'd6,
		op_df = 3'd7
	} fpm_op_t;

	// operation classes tested by the rest of the unit
	typedef struct packed {
		// float add or subtract
		logic af_sf;
		// fixed or float multiply
		logic mw_mf;
		// fixed or float divide
		logic dw_df;
		// fixed add or subtract long
		logic ad_sd;
		// any float op
		logic ff;
		// any fixed op
		logic ss;
	} fpm_class_t;

endpackage

/* fpm_exp_pkg.sv */
`include "fpm_settings.svh"

package fpm_exp_pkg;

	typedef logic signed [`FPM_EXP_W-1:0] exp_t;

	// D register with two guard bits above the exponent
	typedef logic signed [`FPM_EXP_W+1:0] exp_wide_t;

	typedef logic [`FPM_CNT_W-1:0] fic_cnt_t;

	typedef struct packed {
		logic g;
		logic wdt;
		logic wt;
		logic wc;
	} exp_ind_t;

	typedef struct packed {
		logic over;
		logic under;
	} fp_fault_t;

	// D register magnitude fits because D has spare bits
	function automatic exp_wide_t exp_mag(input exp_wide_t v);
		exp_wide_t m;
		if (v[$bits(exp_wide_t)-1]) begin
			m = -v;
		end else begin
			m = v;
		end
		return m;
	endfunction

endpackage

/* fpm_opdec.sv */
`timescale 1ns/1ps

module fpm_opdec (
	input  logic                    wdtwtg_clk,
	input  logic                    _0_f,
	input  logic                    start,
	input  fpm_ops_pkg::fpm_op_t    ir,
	input  logic                    busy,
	output fpm_ops_pkg::fpm_class_t op_class
);
	import fpm_ops_pkg::*;

	fpm_op_t op_q;
	logic    fresh;
	logic    accept;

	// fresh covers the cycle right after a start, before busy rises
	assign accept = start & ~busy & ~fresh;

	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			op_q  <= op_ad;
			fresh <= 1'b0;
		end else begin
			fresh <= accept;
			if (accept) begin
				op_q <= ir;
			end
		end
	end

	// class flags follow the held instruction
	always_comb begin
		op_class.af_sf = (op_q == op_af) || (op_q == op_sf);
		op_class.mw_mf = (op_q == op_mw) || (op_q == op_mf);
		op_class.dw_df = (op_q == op_dw) || (op_q == op_df);
		op_class.ad_sd = (op_q == op_ad) || (op_q == op_sd);
		op_class.ff    = op_q[2];
		op_class.ss    = ~op_q[2];
	end

endmodule

/* fpm_exp_adder.sv */
`timescale 1ns/1ps
`include "fpm_settings.svh"

module fpm_exp_adder (
	input  logic                    wdtwtg_clk,
	input  logic                    _0_f,
	input  logic                    start,
	input  logic                    busy,
	input  fpm_exp_pkg::exp_t       exp_a,
	input  fpm_exp_pkg::exp_t       exp_b,
	input  fpm_ops_pkg::fpm_class_t op_class,
	output fpm_exp_pkg::exp_wide_t  d_reg,
	output logic                    far,
	output logic                    sum_valid
);
	import fpm_exp_pkg::*;

	exp_t      a_reg;
	exp_t      b_reg;
	exp_t      b_bus;
	logic      b_full;
	logic      sub;
	logic      accept;
	exp_wide_t sum;
	exp_wide_t sum_mag;

	// b_full blocks a restart while the operands wait for the adder
	assign accept = start & ~busy & ~b_full;

	// operand latch at the start edge
	always_ff @(posedge wdtwtg_clk) begin
		if (accept) begin
			a_reg <= exp_a;
			b_reg <= exp_b;
		end
	end

	// true B for multiply, inverted B plus carry-in otherwise
	assign sub   = ~op_class.mw_mf;
	assign b_bus = sub ? ~b_reg : b_reg;

	// sign extended into the D width so over/underflow stays visible
	assign sum = exp_wide_t'(a_reg) + exp_wide_t'(b_bus) + exp_wide_t'(sub);

	assign sum_mag = exp_mag(sum);

	// one-cycle phase flags
	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			b_full    <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			b_full    <= accept;
			sum_valid <= b_full;
		end
	end

	// D register and far-difference flag
	always_ff @(posedge wdtwtg_clk) begin
		if (b_full) begin
			d_reg <= sum;
			far   <= sum_mag >= exp_wide_t'(`FPM_FAR_LIMIT);
		end
	end

	// one result strobe per accepted start
	a_sum_valid_pulse: assert property (
		@(posedge wdtwtg_clk) disable iff (_0_f)
		sum_valid |=> !sum_valid
	);

endmodule

/* fpm_fic.sv */
`timescale 1ns/1ps

module fpm_fic (
	input  logic                  wdtwtg_clk,
	input  logic                  _0_f,
	input  logic                  fic_load,
	input  fpm_exp_pkg::fic_cnt_t fic_value,
	input  logic                  shift,
	output fpm_exp_pkg::fic_cnt_t fic,
	output logic                  fic_zero
);
	import fpm_exp_pkg::*;

	// load wins over a shift in the same cycle
	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			fic <= '0;
		end else if (fic_load) begin
			fic <= fic_value;
		end else if (shift && !fic_zero) begin
			fic <= fic - fic_cnt_t'(1);
		end
	end

	assign fic_zero = (fic == '0);

	// without a load the count never rises, so it cannot wrap from zero
	a_fic_no_wrap: assert property (
		@(posedge wdtwtg_clk) disable iff (_0_f)
		!fic_load |=> (fic <= $past(fic))
	);

endmodule

/* fpm_indicators.sv */
`timescale 1ns/1ps
`include "fpm_settings.svh"

module fpm_indicators (
	input  logic                    wdtwtg_clk,
	input  logic                    _0_f,
	input  logic                    sum_valid,
	input  fpm_exp_pkg::exp_wide_t  d_reg,
	input  logic                    far,
	input  fpm_ops_pkg::fpm_class_t op_class,
	input  fpm_exp_pkg::exp_t       exp_a,
	input  fpm_exp_pkg::exp_t       exp_b,
	output fpm_exp_pkg::exp_ind_t   ind,
	output fpm_exp_pkg::fp_fault_t  fault,
	output fpm_exp_pkg::exp_t       exp_res,
	output logic                    fic_load,
	output fpm_exp_pkg::fic_cnt_t   fic_value,
	output logic                    done,
	output logic                    busy
);
	import fpm_exp_pkg::*;

	localparam int EXP_MAX = 2 ** (`FPM_EXP_W - 1) - 1;
	localparam int EXP_MIN = -(2 ** (`FPM_EXP_W - 1));

	exp_wide_t d_mag;
	logic      d_neg;
	logic      fl_arith;
	exp_ind_t  ind_d;
	fp_fault_t fault_d;
	exp_t      res_d;

	assign d_mag    = exp_mag(d_reg);
	assign d_neg    = d_reg[$bits(exp_wide_t)-1];
	// float multiply or divide
	assign fl_arith = op_class.ff & (op_class.mw_mf | op_class.dw_df);

	always_comb begin
		ind_d     = '0;
		fault_d   = '0;
		res_d     = '0;
		fic_value = fic_cnt_t'(`FPM_FIX_STEPS);
		if (op_class.af_sf) begin
			ind_d.g   = far;
			// negative difference shifts T right
			ind_d.wdt = d_neg;
			ind_d.wt  = far & ~d_neg;
			ind_d.wc  = far & d_neg;
			// larger exponent survives
			res_d     = d_neg ? exp_b : exp_a;
			if (far) begin
				fic_value = '0;
			end else begin
				fic_value = d_mag[`FPM_CNT_W-1:0];
			end
		end else if (fl_arith) begin
			fault_d.over  = d_reg > exp_wide_t'(EXP_MAX);
			fault_d.under = d_reg < exp_wide_t'(EXP_MIN);
			// low bits kept even when out of range
			res_d         = d_reg[`FPM_EXP_W-1:0];
			fic_value     = fic_cnt_t'(`FPM_FLOAT_STEPS);
		end
	end

	// counter loads on the same edge the indicators register
	assign fic_load = sum_valid;

	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			ind   <= '0;
			fault <= '0;
			done  <= 1'b0;
		end else begin
			done <= sum_valid;
			if (sum_valid) begin
				ind   <= ind_d;
				fault <= fault_d;
			end
		end
	end

	always_ff @(posedge wdtwtg_clk) begin
		if (sum_valid) begin
			exp_res <= res_d;
		end
	end

	assign busy = sum_valid | done;

	// result cannot sit in both T and C
	a_wt_wc_excl: assert property (
		@(posedge wdtwtg_clk) disable iff (_0_f)
		!(ind.wt && ind.wc)
	);

endmodule

/* fpm.sv */
`timescale 1ns/1ps

module fpm (
	input  logic                   wdtwtg_clk,
	input  logic                   _0_f,
	input  logic                   start,
	input  fpm_ops_pkg::fpm_op_t   ir,
	input  fpm_exp_pkg::exp_t      exp_a,
	input  fpm_exp_pkg::exp_t      exp_b,
	input  logic                   shift,
	output logic                   done,
	output logic                   busy,
	output fpm_exp_pkg::exp_t      exp_res,
	output fpm_exp_pkg::exp_ind_t  ind,
	output fpm_exp_pkg::fp_fault_t fault,
	output fpm_exp_pkg::fic_cnt_t  fic,
	output logic                   fic_zero,
	output logic                   ff,
	output logic                   ss
);
	import fpm_ops_pkg::*;
	import fpm_exp_pkg::*;

	fpm_class_t op_class;
	exp_wide_t  d_reg;
	logic       far;
	logic       sum_valid;
	logic       fic_load;
	fic_cnt_t   fic_value;

	assign ff = op_class.ff;
	assign ss = op_class.ss;

	fpm_opdec opdec_i (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.start      (start),
		.ir         (ir),
		.busy       (busy),
		.op_class   (op_class)
	);

	fpm_exp_adder exp_adder_i (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.start      (start),
		.busy       (busy),
		.exp_a      (exp_a),
		.exp_b      (exp_b),
		.op_class   (op_class),
		.d_reg      (d_reg),
		.far        (far),
		.sum_valid  (sum_valid)
	);

	fpm_indicators indicators_i (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.sum_valid  (sum_valid),
		.d_reg      (d_reg),
		.far        (far),
		.op_class   (op_class),
		.exp_a      (exp_a),
		.exp_b      (exp_b),
		.ind        (ind),
		.fault      (fault),
		.exp_res    (exp_res),
		.fic_load   (fic_load),
		.fic_value  (fic_value),
		.done       (done),
		.busy       (busy)
	);

	fpm_fic fic_i (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.fic_load   (fic_load),
		.fic_value  (fic_value),
		.shift      (shift),
		.fic        (fic),
		.fic_zero   (fic_zero)
	);

endmodule

/* fpm_tb.sv */
`timescale 1ns/1ps
`include "fpm_settings.svh"

module fpm_tb;
	import fpm_ops_pkg::*;
	import fpm_exp_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int SHIFT_BITS   = 5;
	localparam int EXP_HI       = (1 << (`FPM_EXP_W - 1)) - 1;
	localparam int EXP_LO       = -(1 << (`FPM_EXP_W - 1));

	typedef struct packed {
		fpm_op_t   op;
		exp_t      a;
		exp_t      b;
		exp_t      res;
		exp_ind_t  ind;
		fp_fault_t fault;
		fic_cnt_t  fic;
	} vec_t;

	logic       wdtwtg_clk;
	logic       _0_f;
	logic       start;
	fpm_op_t    ir;
	exp_t       exp_a;
	exp_t       exp_b;
	logic       shift;
	logic       done;
	logic       busy;
	exp_t       exp_res;
	exp_ind_t   ind;
	fp_fault_t  fault;
	fic_cnt_t   fic;
	logic       fic_zero;
	logic       ff;
	logic       ss;

	vec_t       vectors[$];
	logic [7:0] lfsr_q = 8'd28;
	int         errors = 0;
	int         rows_ok = 0;
	int         rows_bad = 0;
	int         cycles = 0;
	int         timeout_limit = 0;
	int         done_count = 0;
	int         row_idx;

	fpm fpm_i (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.start      (start),
		.ir         (ir),
		.exp_a      (exp_a),
		.exp_b      (exp_b),
		.shift      (shift),
		.done       (done),
		.busy       (busy),
		.exp_res    (exp_res),
		.ind        (ind),
		.fault      (fault),
		.fic        (fic),
		.fic_zero   (fic_zero),
		.ff         (ff),
		.ss         (ss)
	);

	initial begin
		wdtwtg_clk = 1'b0;
		forever #4 wdtwtg_clk = ~wdtwtg_clk;
	end

	// watchdog
	always @(posedge wdtwtg_clk) begin
		cycles++;
		if (timeout_limit > 0 && cycles >= timeout_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("Verification failed");
			$finish;
		end
	end

	// one done pulse expected per accepted start
	always @(posedge wdtwtg_clk) begin
		if (done === 1'b1) begin
			done_count++;
		end
	end

	task automatic check_value(input string what, input int got, input int want);
		if (got !== want) begin
			errors++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	// galois form with taps for x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		logic [7:0] t;
		t = s >> 1;
		if (s[0]) begin
			t = t ^ 8'hB8;
		end
		return t;
	endfunction

	task automatic draw_shift_count(output int n);
		int k;
		n = 0;
		for (k = 0; k < SHIFT_BITS; k++) begin
			n = (n << 1) | int'(lfsr_q[0]);
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// expected columns from the exponent rules
	function automatic void add_row(input fpm_op_t op, input int a, input int b);
		vec_t v;
		int   d;
		int   mag;
		v.op    = op;
		v.a     = exp_t'(a);
		v.b     = exp_t'(b);
		v.res   = '0;
		v.ind   = '0;
		v.fault = '0;
		v.fic   = fic_cnt_t'(`FPM_FIX_STEPS);
		case (op)
			op_af, op_sf: begin
				d         = a - b;
				mag       = (d < 0) ? -d : d;
				v.ind.g   = (mag >= `FPM_FAR_LIMIT);
				v.ind.wdt = (d < 0);
				v.ind.wt  = v.ind.g && (d > 0);
				v.ind.wc  = v.ind.g && (d < 0);
				v.res     = (a >= b) ? exp_t'(a) : exp_t'(b);
				v.fic     = v.ind.g ? '0 : fic_cnt_t'(mag);
			end
			op_mf, op_df: begin
				d             = (op == op_mf) ? a + b : a - b;
				v.fault.over  = (d > EXP_HI);
				v.fault.under = (d < EXP_LO);
				v.res         = exp_t'(d);
				v.fic         = fic_cnt_t'(`FPM_FLOAT_STEPS);
			end
			default: begin
			end
		endcase
		vectors.push_back(v);
	endfunction

	function automatic void fill_table();
		add_row(op_af, 10, 3);
		add_row(op_sf, -5, 12);
		add_row(op_af, 20, 20);
		add_row(op_af, 39, 0);
		// far apart in both directions
		add_row(op_af, 50, 5);
		add_row(op_sf, -60, 30);
		add_row(op_af, -40, 0);
		add_row(op_af, 127, -128);
		add_row(op_mf, 30, 40);
		add_row(op_mf, 100, 50);
		add_row(op_mf, -100, -60);
		add_row(op_df, 20, -30);
		add_row(op_df, 100, -100);
		add_row(op_df, -90, 90);
		add_row(op_ad, 5, 7);
		add_row(op_sd, -3, 9);
		add_row(op_mw, 64, 64);
		add_row(op_dw, -128, 127);
	endfunction

	task automatic run_row(input int idx, input vec_t v);
		int      lat;
		int      n;
		int      load;
		int      want_fic;
		int      err_before;
		int      done_before;
		logic    want_ff;
		fpm_op_t op_now;
		fpm_op_t alt;
		err_before  = errors;
		done_before = done_count;
		op_now      = v.op;
		alt         = fpm_op_t'(v.op ^ 3'b100);
		load        = int'(v.fic);
		// float ops are the four float codes of the instruction table
		want_ff     = (v.op == op_af) || (v.op == op_sf) ||
			(v.op == op_mf) || (v.op == op_df);
		@(posedge wdtwtg_clk);
		ir    <= v.op;
		exp_a <= v.a;
		exp_b <= v.b;
		start <= 1'b1;
		// start stays high with another code while the unit is busy
		@(posedge wdtwtg_clk);
		ir  <= alt;
		lat = 0;
		do begin
			@(posedge wdtwtg_clk);
			lat++;
			@(negedge wdtwtg_clk);
		end while (done !== 1'b1);
		check_value("done latency", lat, 2);
		check_value("busy with done", int'(busy), 1);
		check_value("exp_res", int'(exp_res), int'(v.res));
		check_value("ind", int'(ind), int'(v.ind));
		check_value("fault", int'(fault), int'(v.fault));
		check_value("fic after load", int'(fic), load);
		check_value("ff", int'(ff), int'(want_ff));
		check_value("ss", int'(ss), int'(!want_ff));
		@(posedge wdtwtg_clk);
		start <= 1'b0;
		@(negedge wdtwtg_clk);
		check_value("done pulse width", int'(done), 0);
		check_value("busy after done", int'(busy), 0);
		draw_shift_count(n);
		repeat (n) begin
			@(posedge wdtwtg_clk);
			shift <= 1'b1;
		end
		@(posedge wdtwtg_clk);
		shift <= 1'b0;
		@(negedge wdtwtg_clk);
		want_fic = (load > n) ? load - n : 0;
		check_value("fic after shifts", int'(fic), want_fic);
		check_value("fic_zero", int'(fic_zero), int'(want_fic == 0));
		check_value("done pulses", done_count - done_before, 1);
		if (errors == err_before) begin
			rows_ok++;
			$display("test %0d %s a=%0d b=%0d shifts=%0d: ok",
				idx, op_now.name(), v.a, v.b, n);
		end else begin
			rows_bad++;
			$display("test %0d %s a=%0d b=%0d shifts=%0d: mismatch",
				idx, op_now.name(), v.a, v.b, n);
		end
	endtask

	initial begin
		_0_f  = 1'b1;
		start = 1'b0;
		ir    = op_ad;
		exp_a = '0;
		exp_b = '0;
		shift = 1'b0;
		fill_table();
		// longest count plus overhead per row
		timeout_limit = vectors.size() * (`FPM_FLOAT_STEPS + 10) + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge wdtwtg_clk);
		_0_f <= 1'b0;
		@(negedge wdtwtg_clk);
		check_value("done after reset", int'(done), 0);
		check_value("busy after reset", int'(busy), 0);
		check_value("ind after reset", int'(ind), 0);
		check_value("fault after reset", int'(fault), 0);
		check_value("fic after reset", int'(fic), 0);
		check_value("fic_zero after reset", int'(fic_zero), 1);
		for (row_idx = 0; row_idx < vectors.size(); row_idx++) begin
			run_row(row_idx, vectors[row_idx]);
		end
		$display("rows %0d, ok %0d, with mismatches %0d, total errors %0d",
			vectors.size(), rows_ok, rows_bad, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
fpm_ops_pkg.sv
fpm_exp_pkg.sv
fpm_opdec.sv
fpm_exp_adder.sv
fpm_fic.sv
fpm_indicators.sv
fpm.sv
fpm_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = fpm_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
